// ==== Bender.yml ====
package:
  name: gf_accel

sources:
  - files:
      - design/gf_pkg.sv
      - design/gf_std_mult.sv
      - design/gf_power.sv
      - design/gf_divider.sv
      - design/gf_alu.sv
      - design/gf_wb_regs.sv
      - design/gf_accel_top.sv
  - target: simulation
    files:
      - dv/gf_accel_assertions.sv
      - dv/gf_accel_tb.sv

// ==== design/gf_accel_top.sv ====
`timescale 1ns/1ps

// GF(2^M) accelerator, bus register file in front of the arithmetic unit
module gf_accel_top #(
	parameter int M = 8
) (
	input  logic            clk,
	input  logic            reset,
	input  gf_pkg::wb_req_t wb_in,
	output gf_pkg::wb_rsp_t wb_out
);
	import gf_pkg::*;

	gf_cmd_t  cmd;						// Launch from the register file
	gf_stat_t stat;						// Status and result back from the ALU

	gf_wb_regs #(
		.M(M)
	) u_regs (
		.clk  (clk),
		.reset(reset),
		.req  (wb_in),
		.rsp  (wb_out),
		.cmd  (cmd),
		.stat (stat)
	);

	gf_alu #(
		.M(M)
	) u_alu (
		.clk  (clk),
		.reset(reset),
		.cmd  (cmd),
		.stat (stat)
	);

endmodule

// ==== design/gf_alu.sv ====
`timescale 1ns/1ps

// Latches the operands of a launch, runs the selected datapath and keeps the
// result and status until the next launch
module gf_alu #(
	parameter int M = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  gf_pkg::gf_cmd_t  cmd,
	output gf_pkg::gf_stat_t stat
);
	import gf_pkg::*;

	logic     launch;					// Launch accepted this cycle
	logic     div_start;					// Launch of a divide
	logic     div_done;					// Divider finished
	gf_op_t   op_q;						// Operation in flight
	gf_elem_t a_q;						// Latched operand A
	gf_elem_t b_q;						// Latched operand B
	gf_elem_t mul_p;					// A times B
	gf_elem_t sq_p;						// A squared
	gf_elem_t cube_p;					// A cubed
	gf_elem_t quot;						// A divided by B

	assign launch = cmd.start && !stat.busy;		// A second launch while busy is lost
	assign div_start = launch && (cmd.op == op_div);

	gf_std_mult #(
		.M(M)
	) u_mult (
		.a(a_q),
		.b(b_q),
		.p(mul_p)
	);

	gf_power #(
		.M(M)
	) u_power (
		.a   (a_q),
		.sq  (sq_p),
		.cube(cube_p)
	);

	// Fed straight from the command so it loads on the launch edge
	gf_divider #(
		.M(M)
	) u_div (
		.clk  (clk),
		.reset(reset),
		.start(div_start),
		.numer(cmd.a),
		.denom(cmd.b),
		.quot (quot),
		.done (div_done)
	);

	always_ff @(posedge clk) begin
		if (launch) begin
			op_q <= cmd.op;
			a_q <= cmd.a;
			b_q <= cmd.b;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stat.busy <= 1'b0;
			stat.div_zero <= 1'b0;
			stat.result <= '0;
		end else if (launch) begin
			stat.busy <= 1'b1;			// Busy from the capturing edge
		end else if (stat.busy) begin
			case (op_q)
				op_mul, op_sqr, op_cube: begin
					stat.busy <= 1'b0;	// Single-cycle datapaths
					stat.div_zero <= 1'b0;
					stat.result <= (op_q == op_mul) ? mul_p :
						(op_q == op_sqr) ? sq_p : cube_p;
				end
				op_div: begin
					if (div_done) begin
						stat.busy <= 1'b0;	// Divide ends when the divider does
						stat.div_zero <= (b_q == '0);
						stat.result <= (b_q == '0) ? '0 : quot;	// No inverse of zero
					end
				end
			endcase
		end
	end

endmodule

// ==== design/gf_divider.sv ====
`timescale 1ns/1ps

// Fermat divider. Computes numer times denom^(2^M-2) as
// numer * d^2 * d^4 * ... * d^(2^(M-1)), one factor per step
module gf_divider #(
	parameter int M = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  gf_pkg::gf_elem_t numer,
	input  gf_pkg::gf_elem_t denom,
	output gf_pkg::gf_elem_t quot,
	output logic             done
);
	import gf_pkg::*;

	localparam int cnt_w = $clog2(M);			// Wide enough to count M-1 steps
	localparam logic [cnt_w-1:0] last_step = cnt_w'(M - 2);	// Steps are numbered from zero

	logic             running;				// Steps still to go
	logic [cnt_w-1:0] step_cnt;				// Index of the step on the next edge
	gf_elem_t         sq_reg;				// Current power d^(2^k)
	gf_elem_t         acc;					// Running product
	gf_elem_t         sq_in;				// Squarer input, denom at load time
	gf_elem_t         sq_next;				// Next power of the denominator
	gf_elem_t         prod;					// acc times current power

	assign sq_in = start ? denom : sq_reg;			// Load squares the fresh denominator

	gf_power #(
		.M(M)
	) u_square (
		.a   (sq_in),
		.sq  (sq_next),
		.cube()						// Only the square is needed here
	);

	gf_std_mult #(
		.M(M)
	) u_accum (
		.a(acc),
		.b(sq_reg),
		.p(prod)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			step_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;				// Pulse for one cycle only
			if (start) begin
				running <= 1'b1;
				step_cnt <= '0;
			end else if (running) begin
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == last_step) begin
					running <= 1'b0;	// Final factor folds in on this edge
					done <= 1'b1;		// acc holds the quotient from here on
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			sq_reg <= sq_next;			// d^2
			acc <= numer;				// Numerator rides along as the seed
		end else if (running) begin
			sq_reg <= sq_next;			// Square again for the next factor
			acc <= prod;				// Multiply in this factor
		end
	end

	assign quot = acc;

endmodule

// ==== design/gf_pkg.sv ====
package gf_pkg;

	localparam int gf_max_m = 8;				// Widest field the datapaths are sized for

	typedef logic [gf_max_m-1:0] gf_elem_t;			// One element, only the low M bits carry data

	// Low M bits of the primitive polynomial, the x^M term is implied
	function automatic gf_elem_t gf_poly(input int m);
		case (m)
			3: return 8'h03;				// x^3+x+1
			4: return 8'h03;				// x^4+x+1
			5: return 8'h05;				// x^5+x^2+1
			6: return 8'h03;				// x^6+x+1
			7: return 8'h03;				// x^7+x+1
			8: return 8'h1d;				// x^8+x^4+x^3+x^2+1
			default: return '0;				// Outside the table, no reduction
		endcase
	endfunction

	// Mask of the M bits that belong to an element
	function automatic gf_elem_t gf_mask(input int m);
		return gf_elem_t'((1 << m) - 1);
	endfunction

	// Multiply by alpha, one shift and a conditional reduction
	function automatic gf_elem_t gf_mul_alpha(input int m, input gf_elem_t x);
		gf_elem_t y;
		y = (x << 1) & gf_mask(m);				// Top bit falls out of the field
		if (x[m-1])
			y = y ^ gf_poly(m);				// Fold x^M back in as the polynomial tail
		return y;
	endfunction

	// Alpha raised to n, used to build constant matrices at elaboration
	function automatic gf_elem_t gf_alpha_pow(input int m, input int n);
		gf_elem_t x;
		x = gf_elem_t'(1);					// Alpha^0
		for (int k = 0; k < n; k++)
			x = gf_mul_alpha(m, x);
		return x;
	endfunction

	typedef enum logic [1:0] {
		op_mul,							// A times B
		op_sqr,							// A squared
		op_cube,						// A cubed
		op_div							// A divided by B
	} gf_op_t;

	typedef enum logic [2:0] {
		reg_a      = 3'd0,					// Operand A
		reg_b      = 3'd1,					// Operand B
		reg_cmd    = 3'd2,					// Launch, op in bits 1:0
		reg_result = 3'd3,					// Last result, zero-extended
		reg_status = 3'd4					// Busy in bit 0, div_zero in bit 1
	} gf_addr_t;

	typedef struct packed {
		logic        cyc;					// Bus cycle in progress
		logic        stb;					// Strobe for this transfer
		logic        we;					// High for a write
		logic [2:0]  adr;					// Word address
		logic [31:0] dat;					// Write data
	} wb_req_t;

	typedef struct packed {
		logic        ack;					// One-cycle acknowledge
		logic [31:0] dat;					// Read data, valid with ack
	} wb_rsp_t;

	typedef struct packed {
		logic     start;					// Single-cycle launch
		gf_op_t   op;						// Operation to run
		gf_elem_t a;						// First operand
		gf_elem_t b;						// Second operand
	} gf_cmd_t;

	typedef struct packed {
		logic     busy;						// Operation in flight
		logic     div_zero;					// Last divide had a zero divisor
		gf_elem_t result;					// Last completed result
	} gf_stat_t;

endpackage

// ==== design/gf_power.sv ====
`timescale 1ns/1ps

// Square and cube of one element in standard basis. Both are sums of constant
// columns selected by the bits of a, with extra pair terms for the cube
module gf_power #(
	parameter int M = 8
) (
	input  gf_pkg::gf_elem_t a,
	output gf_pkg::gf_elem_t sq,
	output gf_pkg::gf_elem_t cube
);
	import gf_pkg::*;

	typedef gf_elem_t [M-1:0] gf_map_t;			// One reduced column per input bit
	typedef gf_elem_t [M-1:0][M-1:0] gf_cross_t;		// One column per bit pair

	// Column j is alpha^(power*j), reduced
	function automatic gf_map_t linear_map(input int power);
		gf_map_t map;
		for (int k = 0; k < M; k++)
			map[k] = gf_alpha_pow(M, power * k);
		return map;
	endfunction

	// Pair term for i < k is alpha^(2i+k) + alpha^(2k+i), zero elsewhere
	function automatic gf_cross_t cross_map();
		gf_cross_t map;
		map = '0;
		for (int n = 0; n < M; n++)
			for (int k = n + 1; k < M; k++)
				map[n][k] = gf_alpha_pow(M, 2 * n + k) ^ gf_alpha_pow(M, 2 * k + n);
		return map;
	endfunction

	localparam gf_map_t   sq_map     = linear_map(2);	// Squaring is linear over GF(2)
	localparam gf_map_t   cube_map   = linear_map(3);	// Diagonal part of the cube
	localparam gf_cross_t cube_cross = cross_map();		// Off-diagonal part of the cube

	always_comb begin
		sq = '0;
		cube = '0;
		for (int n = 0; n < M; n++) begin
			sq ^= sq_map[n] & {gf_max_m{a[n]}};		// a_n alpha^(2n)
			cube ^= cube_map[n] & {gf_max_m{a[n]}};	// a_n alpha^(3n)
			for (int k = n + 1; k < M; k++)
				cube ^= cube_cross[n][k] & {gf_max_m{a[n] & a[k]}};	// Odd count pair terms
		end
	end

endmodule

// ==== design/gf_std_mult.sv ====
`timescale 1ns/1ps

// Bit-parallel multiplier in standard basis. Each product bit is the parity of
// b against one column of the alpha-shifted copies of a
module gf_std_mult #(
	parameter int M = 8
) (
	input  gf_pkg::gf_elem_t a,
	input  gf_pkg::gf_elem_t b,
	output gf_pkg::gf_elem_t p
);
	import gf_pkg::*;

	gf_elem_t copies [M];					// copies[j] holds a times alpha^j

	genvar i, j;

	for (j = 0; j < M; j++) begin : g_copy
		if (j == 0) begin : g_base
			assign copies[j] = a & gf_mask(M);		// Upper bits of a are not part of the field
		end else begin : g_shift
			assign copies[j] = gf_mul_alpha(M, copies[j-1]);	// One more power of alpha
		end
	end

	for (i = 0; i < gf_max_m; i++) begin : g_bit
		if (i < M) begin : g_used
			logic [M-1:0] column;				// Bit i of every copy

			for (j = 0; j < M; j++) begin : g_col
				assign column[j] = copies[j][i];
			end

			assign p[i] = ^(b[M-1:0] & column);		// Sum of b_j times (a alpha^j)_i
		end else begin : g_unused
			assign p[i] = 1'b0;				// Above the field degree
		end
	end

endmodule

// ==== design/gf_wb_regs.sv ====
`timescale 1ns/1ps

// Wishbone classic slave with one wait state. Holds the operands, turns a
// command write into a launch and returns result and status
module gf_wb_regs #(
	parameter int M = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  gf_pkg::wb_req_t  req,
	output gf_pkg::wb_rsp_t  rsp,
	output gf_pkg::gf_cmd_t  cmd,
	input  gf_pkg::gf_stat_t stat
);
	import gf_pkg::*;

	logic        ack_q;					// Acknowledge for the current strobe
	logic [31:0] rd_q;					// Read data captured with ack
	logic [31:0] rd_mux;					// Read data for the current address
	logic        access;					// New strobe seen this cycle
	logic        wr_en;					// Write takes effect on this edge
	gf_addr_t    addr;					// Decoded word address
	gf_elem_t    a_q;					// Operand A register
	gf_elem_t    b_q;					// Operand B register

	assign addr = gf_addr_t'(req.adr);
	assign access = req.cyc && req.stb && !ack_q;		// Strobe already acked is not served again
	assign wr_en = access && req.we;

	// Launch is combinational so the ALU captures it on the ack edge
	assign cmd.start = wr_en && (addr == reg_cmd) && !stat.busy;
	assign cmd.op = gf_op_t'(req.dat[1:0]);
	assign cmd.a = a_q;
	assign cmd.b = b_q;

	always_comb begin
		case (addr)
			reg_a:      rd_mux = 32'(a_q);
			reg_b:      rd_mux = 32'(b_q);
			reg_result: rd_mux = 32'(stat.result);	// Zero-extended
			reg_status: rd_mux = {30'd0, stat.div_zero, stat.busy};
			default:    rd_mux = '0;		// Command register and holes read zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
			a_q <= '0;
			b_q <= '0;
		end else begin
			ack_q <= access;			// One cycle after the strobe, never twice
			if (wr_en) begin
				case (addr)
					reg_a: a_q <= req.dat[gf_max_m-1:0] & gf_mask(M);
					reg_b: b_q <= req.dat[gf_max_m-1:0] & gf_mask(M);
					default: ;		// Command is handled as a launch, others dropped
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access && !req.we)
			rd_q <= rd_mux;				// Valid in the ack cycle
	end

	assign rsp.ack = ack_q;
	assign rsp.dat = rd_q;

endmodule

// ==== dv/gf_accel_assertions.sv ====
`timescale 1ns/1ps

// Bus handshake and busy timing checks. The register file sees both the bus
// and the launch together with the busy status that comes back from the ALU
module gf_accel_assertions #(
	parameter int M = 8
) (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic start,
	input logic busy
);
	int error_count = 0;					// Failures seen so far

	a_ack_after_strobe: assert property (@(posedge clk) disable iff (reset)
		ack |-> cyc && stb)				// Ack only while the master still strobes
	else begin
		$error("ack raised while cyc and stb were low");
		error_count++;
	end

	a_ack_single: assert property (@(posedge clk) disable iff (reset)
		ack |=> !ack)					// One ack per strobe
	else begin
		$error("ack held high for two cycles");
		error_count++;
	end

	a_busy_bounded: assert property (@(posedge clk) disable iff (reset)
		start |=> busy ##[1:M] !busy)			// Divide is the longest at M cycles
	else begin
		$error("busy did not rise on launch or stayed high past M cycles");
		error_count++;
	end

endmodule

bind gf_wb_regs gf_accel_assertions #(
	.M(M)
) bus_chk (
	.clk  (clk),
	.reset(reset),
	.cyc  (req.cyc),
	.stb  (req.stb),
	.ack  (rsp.ack),
	.start(cmd.start),
	.busy (stat.busy)
);

// ==== dv/gf_accel_tb.sv ====
`timescale 1ns/1ps

// Directed testbench for the GF(2^8) accelerator. Expected values come from a
// shift-and-reduce field model and an inverse found by exhaustive search
module gf_accel_tb;
	import gf_pkg::*;

	localparam logic [7:0] field_tail = 8'h1d;		// x^8+x^4+x^3+x^2+1 without x^8
	localparam int cycle_limit = 20000;			// About 700 operations of under 25 cycles

	logic    clk = 1'b0;
	logic    reset;
	wb_req_t req;						// Bus master side
	wb_rsp_t rsp;						// Bus slave side
	int      cycle_cnt = 0;

	gf_accel_top #(
		.M(8)
	) dut_i (
		.clk   (clk),
		.reset (reset),
		.wb_in (req),
		.wb_out(rsp)
	);

	always #5 clk = ~clk;					// 10 ns period

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == cycle_limit)
			stop_run($sformatf("Timeout, the tests did not finish in %0d cycles",
				cycle_limit));
	end

	// Shift-and-reduce product where x^8 folds back as the polynomial tail
	function automatic logic [7:0] model_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] x;
		logic [7:0] p;
		x = a;
		p = 8'h00;
		for (int n = 0; n < 8; n++) begin
			if (b[n])
				p = p ^ x;				// Add a times alpha^n
			x = x[7] ? ((x << 1) ^ field_tail) : (x << 1);
		end
		return p;
	endfunction

	// The unique x with b times x equal to one. Zero has none
	function automatic logic [7:0] model_inv(input logic [7:0] b);
		for (int x = 1; x < 256; x++)
			if (model_mul(b, 8'(x)) == 8'h01)
				return 8'(x);
		return 8'h00;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else stop_run($sformatf("FAIL %0t: %s read %h, expected %h", $time, what,
			got, expected));
	endtask

	// One classic cycle that is held until ack and then released for an idle cycle
	task automatic bus_transfer(input logic we, input logic [2:0] adr,
		input logic [31:0] wdat, output logic [31:0] rdat);
		@(posedge clk);
		req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do
			@(posedge clk);
		while (!rsp.ack);
		rdat = rsp.dat;					// Read data is valid with ack
		req <= '0;
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_transfer(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
		bus_transfer(1'b0, adr, 32'd0, dat);
	endtask

	task automatic wait_idle(output logic [31:0] status);
		do
			wb_read(reg_status, status);
		while (status[0]);					// Poll until busy drops
	endtask

	task automatic run_op(input gf_op_t op, output logic [31:0] result,
		output logic [31:0] status);
		wb_write(reg_cmd, 32'(op));
		wait_idle(status);
		wb_read(reg_result, result);
	endtask

	task automatic test_registers();
		logic [31:0] rdat;
		logic [31:0] a_raw;
		logic [31:0] b_raw;
		a_raw = $urandom;
		b_raw = $urandom;
		wb_read(reg_status, rdat);
		check_value("status after reset", rdat, 32'd0);
		wb_read(reg_result, rdat);
		check_value("result after reset", rdat, 32'd0);
		wb_write(reg_a, a_raw);
		wb_write(reg_b, b_raw);
		wb_read(reg_a, rdat);
		check_value("operand A readback", rdat, a_raw & 32'hff);
		wb_read(reg_b, rdat);
		check_value("operand B readback", rdat, b_raw & 32'hff);
		for (int adr = 5; adr < 8; adr++) begin
			wb_write(3'(adr), 32'hffff_ffff);	// Should land nowhere
			wb_read(3'(adr), rdat);
			check_value($sformatf("unmapped address %0d", adr), rdat, 32'd0);
		end
		wb_read(reg_a, rdat);
		check_value("operand A after unmapped writes", rdat, a_raw & 32'hff);
	endtask

	task automatic test_multiply();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [31:0] result;
		logic [31:0] status;
		for (int n = 0; n < 200; n++) begin
			a = (n == 2) ? 8'h01 : 8'($urandom);	// Third pair checks one times B
			b = (n == 0) ? 8'h01 : ((n == 1) ? 8'h00 : 8'($urandom));
			wb_write(reg_a, 32'(a));
			wb_write(reg_b, 32'(b));
			run_op(op_mul, result, status);
			check_value($sformatf("%h times %h", a, b), result, 32'(model_mul(a, b)));
			check_value("status after multiply", status, 32'd0);
			if (b == 8'h01)
				check_value("multiply by one", result, 32'(a));
			if (b == 8'h00)
				check_value("multiply by zero", result, 32'd0);
		end
	endtask

	task automatic test_powers();
		logic [7:0]  a;
		logic [31:0] result;
		logic [31:0] status;
		for (int n = 0; n < 100; n++) begin
			a = 8'($urandom);
			wb_write(reg_a, 32'(a));
			run_op(op_sqr, result, status);
			check_value($sformatf("square of %h", a), result, 32'(model_mul(a, a)));
			run_op(op_cube, result, status);
			check_value($sformatf("cube of %h", a), result,
				32'(model_mul(model_mul(a, a), a)));
		end
	endtask

	task automatic test_divide();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [31:0] result;
		logic [31:0] status;
		for (int n = 0; n < 200; n++) begin
			a = 8'($urandom);
			b = 8'($urandom_range(1, 255));		// Nonzero divisor
			wb_write(reg_a, 32'(a));
			wb_write(reg_b, 32'(b));
			wb_write(reg_cmd, 32'(op_div));
			wb_read(reg_status, status);
			check_value("busy right after divide launch", status & 32'h1, 32'h1);
			wait_idle(status);
			wb_read(reg_result, result);
			check_value("div_zero after divide", status, 32'd0);
			check_value($sformatf("(%h / %h) times %h", a, b, b),
				32'(model_mul(result[7:0], b)), 32'(a));
			check_value($sformatf("%h / %h", a, b), result,
				32'(model_mul(a, model_inv(b))));
		end
	endtask

	task automatic test_div_zero_lockout();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [31:0] result;
		logic [31:0] status;
		a = 8'($urandom_range(1, 255));
		wb_write(reg_a, 32'(a));
		wb_write(reg_b, 32'd0);
		run_op(op_div, result, status);
		check_value("result of divide by zero", result, 32'd0);
		check_value("status after divide by zero", status, 32'h2);
		run_op(op_mul, result, status);
		check_value("status after multiply following zero divide", status, 32'd0);
		b = 8'($urandom_range(2, 255));		// A quotient that differs from the product
		wb_write(reg_b, 32'(b));
		wb_write(reg_cmd, 32'(op_div));
		wb_write(reg_cmd, 32'(op_mul));			// Lands while the divide is busy
		wait_idle(status);
		wb_read(reg_result, result);
		check_value("result after launch during busy", result,
			32'(model_mul(a, model_inv(b))));
		wb_read(reg_status, status);
		check_value("status after launch during busy", status, 32'd0);
	endtask

	initial begin
		int assert_fails;
		reset = 1'b1;
		req = '0;
		void'($urandom(32'h8bec2451));
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		test_registers();
		test_multiply();
		test_powers();
		test_divide();
		test_div_zero_lockout();
		assert_fails = dut_i.u_regs.bus_chk.error_count;
		if (assert_fails == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stop_run($sformatf("Bus or busy timing assertions failed %0d times",
				assert_fails));
		end
	end

endmodule

// ==== tb.f ====
design/gf_pkg.sv
design/gf_std_mult.sv
design/gf_power.sv
design/gf_divider.sv
design/gf_alu.sv
design/gf_wb_regs.sv
design/gf_accel_top.sv
dv/gf_accel_assertions.sv
dv/gf_accel_tb.sv
